/* flow_pkg.sv */
package flow_pkg;

	// ==========================================================================
	// Handshake side of the dispatcher
	// ==========================================================================

	// Output ports fed by the broadcast fork
	localparam int N_LANES = 2;

	// Drop counter width
	// Counter wraps at 2**CNT_W
	localparam int CNT_W = 8;

	// ==========================================================================
	// Types
	// ==========================================================================

	// Wrapping drop count
	typedef logic [CNT_W-1:0] cnt_t;

	// One bit per output lane
	// Used for per-lane rdy, ack and the fork mask
	typedef logic [N_LANES-1:0] lane_mask_t;

endpackage

/* data_pkg.sv */
package data_pkg;

	// ==========================================================================
	// Payload widths
	// ==========================================================================

	// Value carried by every word
	localparam int DATA_W = 16;

	// Tag added to the value on the way through
	localparam int TAG_W = 4;

	// ==========================================================================
	// Payload structs
	// ==========================================================================

	// Word as offered by the source
	// Drop flag in the MSB
	typedef struct packed {
		logic drop;
		logic [TAG_W-1:0] tag;
		logic [DATA_W-1:0] data;
	} sample_t;

	// Word as delivered on each output lane
	// Data already holds value plus tag, mod 2**DATA_W
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [DATA_W-1:0] data;
	} result_t;

endpackage

/* rdyack_stage.sv */
`timescale 1ns/1ps

// One-entry forwarding register on a rdy/ack link
// Full throughput, one word per cycle with no bubble
module rdyack_stage #(
	parameter type T = logic
) (
	input  logic i_clk,
	input  logic i_rst,
	// Upstream side
	input  logic i_src_rdy,
	input  T     i_src_data,
	output logic o_src_ack,
	// Downstream side
	output logic o_dst_rdy,
	output T     o_dst_data,
	input  logic i_dst_ack
);

	// ==========================================================================
	// Internal
	// ==========================================================================

	// Holds a word for downstream
	logic full_r;
	logic full_nxt;
	// Payload register
	T     data_r;

	// ==========================================================================
	// Combinational
	// ==========================================================================

	// Take a word when empty or when the held one leaves this cycle
	assign o_src_ack = i_src_rdy && (!full_r || i_dst_ack);

	// Stay full on a new word, or while the held word waits
	assign full_nxt = i_src_rdy || (full_r && !i_dst_ack);

	assign o_dst_rdy  = full_r;
	assign o_dst_data = data_r;

	// ==========================================================================
	// Sequential
	// ==========================================================================

	// Control state
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			full_r <= 1'b0;
		end else begin
			full_r <= full_nxt;
		end
	end

	// Payload, loaded on every accepted word
	always_ff @(posedge i_clk) begin
		if (o_src_ack) begin
			data_r <= i_src_data;
		end
	end

	// ==========================================================================
	// Assertions
	// ==========================================================================

	// Offered word stays put until downstream takes it
	a_hold_stable: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		(o_dst_rdy && !i_dst_ack) |=> (o_dst_rdy && $stable(o_dst_data))
	);

endmodule

/* ingress_filter.sv */
`timescale 1ns/1ps

// Drop filter and result former
// Flagged words are consumed here and counted
// Kept words go on as tag plus (data + tag)
module ingress_filter import flow_pkg::*, data_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst,
	// From input stage
	input  logic    i_src_rdy,
	input  sample_t i_src_data,
	output logic    o_src_ack,
	// Toward broadcast fork
	output logic    o_dst_rdy,
	output result_t o_dst_data,
	input  logic    i_dst_ack,
	// Status
	output cnt_t    o_drop_cnt
);

	// ==========================================================================
	// Internal
	// ==========================================================================

	// Current word carries the drop flag
	logic    is_drop;
	// Flagged word consumed this cycle
	logic    drop_take;
	// Tag widened to the data width
	logic [DATA_W-1:0] tag_ext;
	// Wrapping drop counter
	cnt_t    drop_cnt_r;

	// ==========================================================================
	// Combinational
	// ==========================================================================

	assign is_drop = i_src_data.drop;

	// Only unflagged words are offered downstream
	assign o_dst_rdy = i_src_rdy && !is_drop;

	// Flagged words never wait on downstream
	assign drop_take = i_src_rdy && is_drop;

	// Upstream ack from either path
	assign o_src_ack = drop_take || (o_dst_rdy && i_dst_ack);

	// Zero-extend tag for the add
	assign tag_ext = {{(DATA_W - TAG_W){1'b0}}, i_src_data.tag};

	// Result word
	// Sum wraps at 2**DATA_W
	always_comb begin
		o_dst_data.tag  = i_src_data.tag;
		o_dst_data.data = i_src_data.data + tag_ext;
	end

	assign o_drop_cnt = drop_cnt_r;

	// ==========================================================================
	// Sequential
	// ==========================================================================

	// Counter steps once per consumed flagged word
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			drop_cnt_r <= '0;
		end else if (drop_take) begin
			drop_cnt_r <= drop_cnt_r + cnt_t'(1);
		end
	end

	// ==========================================================================
	// Assertions
	// ==========================================================================

	// Downstream never takes a flagged word
	a_no_flagged_out: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		(i_src_rdy && is_drop) |-> !i_dst_ack
	);

endmodule

/* broadcast_fork.sv */
`timescale 1ns/1ps

// Copies one result to every output lane
// Source ack only after the last lane has taken its copy
module broadcast_fork import flow_pkg::*, data_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst,
	// From filter
	input  logic       i_src_rdy,
	input  result_t    i_src_data,
	output logic       o_src_ack,
	// Toward lane stages
	output lane_mask_t o_dst_rdys,
	output result_t    o_dst_data,
	input  lane_mask_t i_dst_acks
);

	// ==========================================================================
	// Internal
	// ==========================================================================

	// Lanes that already hold the current result
	lane_mask_t taken_r;
	// Taken lanes including this cycle's acks
	lane_mask_t taken_nxt;
	// Every lane done with the current result
	logic       all_taken;

	// ==========================================================================
	// Combinational
	// ==========================================================================

	// Offer only to lanes still missing this word
	assign o_dst_rdys = i_src_rdy ? ~taken_r : '0;

	// Same payload on every lane
	assign o_dst_data = i_src_data;

	// Fold in acks arriving now
	assign taken_nxt = taken_r | i_dst_acks;
	assign all_taken = &taken_nxt;

	// Last lane ack releases the source
	assign o_src_ack = i_src_rdy && all_taken;

	// ==========================================================================
	// Sequential
	// ==========================================================================

	// Mask clears when the source moves on
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			taken_r <= '0;
		end else if (o_src_ack) begin
			taken_r <= '0;
		end else begin
			taken_r <= taken_nxt;
		end
	end

	// ==========================================================================
	// Assertions
	// ==========================================================================

	// Lane stages answer only to an offer
	a_lane_ack_rdy: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		(i_dst_acks & ~o_dst_rdys) == '0
	);

	// Per lane, a copy left earlier or leaves now before the source is released
	for (genvar gi = 0; gi < N_LANES; gi++) begin : g_chk
		a_src_ack_lane: assert property (
			@(posedge i_clk) disable iff (!i_rst)
			o_src_ack |-> (taken_r[gi] || (o_dst_rdys[gi] && i_dst_acks[gi]))
		);
	end

endmodule

/* stream_dispatch.sv */
`timescale 1ns/1ps

// Stream dispatcher top
// Input stage -> drop filter -> broadcast fork -> one stage per lane
module stream_dispatch import flow_pkg::*, data_pkg::*; (
	input  logic                   i_clk,
	input  logic                   i_rst,
	// Source side
	input  logic                   i_in_rdy,
	input  sample_t                i_in_data,
	output logic                   o_in_ack,
	// Output lanes
	output lane_mask_t             o_out_rdy,
	output result_t [N_LANES-1:0]  o_out_data,
	input  lane_mask_t             i_out_ack,
	// Status
	output cnt_t                   o_drop_cnt
);

	// ==========================================================================
	// Internal links
	// ==========================================================================

	// Input stage to filter
	logic       stg_rdy;
	sample_t    stg_data;
	logic       stg_ack;

	// Filter to fork
	logic       flt_rdy;
	result_t    flt_data;
	logic       flt_ack;

	// Fork to lane stages
	lane_mask_t fork_rdys;
	result_t    fork_data;
	lane_mask_t fork_acks;

	// ==========================================================================
	// Input register
	// ==========================================================================

	rdyack_stage #(.T(sample_t)) i_in_stage (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_src_rdy  (i_in_rdy),
		.i_src_data (i_in_data),
		.o_src_ack  (o_in_ack),
		.o_dst_rdy  (stg_rdy),
		.o_dst_data (stg_data),
		.i_dst_ack  (stg_ack)
	);

	// Drop, count and form result
	ingress_filter i_ingress_filter (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_src_rdy  (stg_rdy),
		.i_src_data (stg_data),
		.o_src_ack  (stg_ack),
		.o_dst_rdy  (flt_rdy),
		.o_dst_data (flt_data),
		.i_dst_ack  (flt_ack),
		.o_drop_cnt (o_drop_cnt)
	);

	// Copy to all lanes
	broadcast_fork i_broadcast_fork (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_src_rdy  (flt_rdy),
		.i_src_data (flt_data),
		.o_src_ack  (flt_ack),
		.o_dst_rdys (fork_rdys),
		.o_dst_data (fork_data),
		.i_dst_acks (fork_acks)
	);

	// ==========================================================================
	// Per-lane output registers
	// ==========================================================================

	// Each lane stalls on its own ack only
	for (genvar gi = 0; gi < N_LANES; gi++) begin : g_lane
		rdyack_stage #(.T(result_t)) i_out_stage (
			.i_clk      (i_clk),
			.i_rst      (i_rst),
			.i_src_rdy  (fork_rdys[gi]),
			.i_src_data (fork_data),
			.o_src_ack  (fork_acks[gi]),
			.o_dst_rdy  (o_out_rdy[gi]),
			.o_dst_data (o_out_data[gi]),
			.i_dst_ack  (i_out_ack[gi])
		);
	end

endmodule

/* tb_stream_dispatch.sv */
`timescale 1ns/1ps

module tb_stream_dispatch import flow_pkg::*, data_pkg::*; ();

	// ==========================================================================
	// Run length
	// ==========================================================================

	// Words per test
	localparam int N_BASIC = 64;
	// Enough flagged words to wrap the 8-bit drop counter
	localparam int N_WRAP  = 330;
	localparam int N_STALL = 16;
	localparam int N_RAND  = 400;
	localparam int N_TOTAL = N_BASIC + N_WRAP + N_STALL + N_RAND;
	// Cycle budget for the whole run
	localparam int CYCLE_LIMIT = 20 * N_TOTAL + 200;

	// Lane ack behavior
	localparam int ACK_ALL    = 0;
	localparam int ACK_STALL0 = 1;
	localparam int ACK_RANDOM = 2;

	logic                  i_clk;
	logic                  i_rst;
	logic                  i_in_rdy;
	sample_t               i_in_data;
	logic                  o_in_ack;
	lane_mask_t            o_out_rdy;
	result_t [N_LANES-1:0] o_out_data;
	lane_mask_t            i_out_ack;
	cnt_t                  o_drop_cnt;

	integer  seed = 39503;
	int      ack_mode = ACK_ALL;
	int      value_errs = 0;
	int      other_errs = 0;
	// Flagged words accepted at the input
	int      drop_total = 0;
	// Cycles with the input offered but not taken
	int      in_stall_cnt = 0;
	int      cycles = 0;
	// Expected results per lane, oldest first
	result_t q_lane0[$];
	result_t q_lane1[$];

	stream_dispatch i_stream_dispatch (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_in_rdy   (i_in_rdy),
		.i_in_data  (i_in_data),
		.o_in_ack   (o_in_ack),
		.o_out_rdy  (o_out_rdy),
		.o_out_data (o_out_data),
		.i_out_ack  (i_out_ack),
		.o_drop_cnt (o_drop_cnt)
	);

	// ==========================================================================
	// Reference model and checks
	// ==========================================================================

	// Result value is data plus tag, wrapped to 16 bits
	function automatic result_t expected_result(sample_t s);
		result_t r;
		int      sum;
		sum = int'(s.data) + int'(s.tag);
		r.tag = s.tag;
		r.data = DATA_W'(sum % (1 << DATA_W));
		return r;
	endfunction

	function automatic sample_t random_sample(logic drop);
		sample_t s;
		s.drop = drop;
		s.tag = TAG_W'($random(seed));
		s.data = DATA_W'($random(seed));
		return s;
	endfunction

	task automatic check_result(string name, result_t exp, result_t got);
		if (got !== exp) begin
			$display("ERR %s expected %h seen %h", name, exp, got);
			value_errs++;
		end
	endtask

	task automatic check_count(string name, cnt_t exp, cnt_t got);
		if (got !== exp) begin
			$display("ERR %s expected %h seen %h", name, exp, got);
			value_errs++;
		end
	endtask

	task automatic check_mask(string name, lane_mask_t exp, lane_mask_t got);
		if (got !== exp) begin
			$display("ERR %s expected %h seen %h", name, exp, got);
			value_errs++;
		end
	endtask

	// One output transfer on a lane, matched against that lane's queue
	task automatic take_output(int lane, result_t got);
		result_t exp;
		string   name;
		name = $sformatf("o_out_data[%0d]", lane);
		if (lane == 0 && q_lane0.size() > 0) begin
			exp = q_lane0.pop_front();
			check_result(name, exp, got);
		end else if (lane == 1 && q_lane1.size() > 0) begin
			exp = q_lane1.pop_front();
			check_result(name, exp, got);
		end else begin
			$display("Lane %0d delivered word %h while nothing was expected", lane, got);
			other_errs++;
		end
	endtask

	// Offer one word after gap idle cycles, hold it until acked
	task automatic send_word(sample_t w, int gap);
		if (gap > 0) begin
			@(negedge i_clk);
			i_in_rdy = 1'b0;
			repeat (gap - 1) @(negedge i_clk);
		end
		@(negedge i_clk);
		i_in_rdy = 1'b1;
		i_in_data = w;
		@(posedge i_clk);
		while (!o_in_ack) @(posedge i_clk);
		// Accepted at this edge
		if (w.drop) begin
			drop_total++;
		end else begin
			q_lane0.push_back(expected_result(w));
			q_lane1.push_back(expected_result(w));
		end
	endtask

	// Stop offering and wait for both lanes to empty
	task automatic drain();
		@(negedge i_clk);
		i_in_rdy = 1'b0;
		while (q_lane0.size() != 0 || q_lane1.size() != 0) @(posedge i_clk);
		// Trailing flagged words still reach the counter
		repeat (4) @(posedge i_clk);
		@(negedge i_clk);
	endtask

	task automatic report_counts();
		$display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
	endtask

	// ==========================================================================
	// Clock, lane acks, compare, timeout
	// ==========================================================================

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	// Lane acks only while that lane offers a word
	initial begin
		i_out_ack = '0;
		forever begin
			@(negedge i_clk);
			case (ack_mode)
				ACK_STALL0: i_out_ack = o_out_rdy & ~lane_mask_t'(1);
				ACK_RANDOM: i_out_ack = o_out_rdy & lane_mask_t'($random(seed));
				default:    i_out_ack = o_out_rdy;
			endcase
		end
	end

	// Compare each output transfer
	initial begin
		forever begin
			@(posedge i_clk);
			if (i_rst) begin
				for (int l = 0; l < N_LANES; l++) begin
					if (o_out_rdy[l] && i_out_ack[l]) begin
						take_output(l, o_out_data[l]);
					end
				end
			end
		end
	end

	// Input back-pressure monitor
	initial begin
		forever begin
			@(posedge i_clk);
			if (i_rst && i_in_rdy && !o_in_ack) begin
				in_stall_cnt++;
			end
		end
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge i_clk);
			cycles++;
		end
		$display("Timeout after %0d cycles with %0d and %0d words still queued",
			cycles, q_lane0.size(), q_lane1.size());
		other_errs++;
		report_counts();
		$display(">>> FAIL");
		$finish;
	end

	// ==========================================================================
	// Test sequence
	// ==========================================================================

	initial begin
		int stall_start;
		i_rst = 1'b0;
		i_in_rdy = 1'b0;
		i_in_data = '0;
		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b1;

		// Idle outputs after reset
		@(negedge i_clk);
		check_mask("o_out_rdy", '0, o_out_rdy);
		check_count("o_drop_cnt", '0, o_drop_cnt);

		// Back-to-back kept words, both lanes free
		for (int i = 0; i < N_BASIC; i++) send_word(random_sample(1'b0), 0);
		drain();

		// Mostly flagged, counter wraps
		for (int i = 0; i < N_WRAP; i++) send_word(random_sample(i % 5 != 0), 0);
		drain();
		check_count("o_drop_cnt", cnt_t'(drop_total), o_drop_cnt);

		// Lane 0 stalled, lane 1 free
		ack_mode = ACK_STALL0;
		stall_start = in_stall_cnt;
		fork
			begin
				for (int i = 0; i < N_STALL; i++) send_word(random_sample(1'b0), 0);
			end
			begin
				repeat (60) @(posedge i_clk);
				if (in_stall_cnt - stall_start < 10) begin
					$display("Input kept accepting words while lane 0 was stalled");
					other_errs++;
				end
				ack_mode = ACK_ALL;
			end
		join
		drain();

		// Random gaps, random lane acks, about one word in four flagged
		ack_mode = ACK_RANDOM;
		for (int i = 0; i < N_RAND; i++) begin
			send_word(random_sample(($random(seed) & 3) == 0), int'({$random(seed)} % 3));
		end
		drain();
		ack_mode = ACK_ALL;

		repeat (2) @(negedge i_clk);
		check_count("o_drop_cnt", cnt_t'(drop_total), o_drop_cnt);
		check_mask("o_out_rdy", '0, o_out_rdy);
		if (q_lane0.size() != 0 || q_lane1.size() != 0) begin
			$display("Words never delivered: %0d on lane 0, %0d on lane 1",
				q_lane0.size(), q_lane1.size());
			other_errs++;
		end

		report_counts();
		if (value_errs == 0 && other_errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* compile.f */
flow_pkg.sv
data_pkg.sv
rdyack_stage.sv
ingress_filter.sv
broadcast_fork.sv
stream_dispatch.sv
tb_stream_dispatch.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_stream_dispatch \
	-o sim_stream_dispatch > build.log 2>&1 \
	&& ./obj_dir/sim_stream_dispatch > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log \
	&& { echo "Simulation reported failure"; exit 1; } \
	|| { echo "Simulation finished without failure"; exit 0; }
